// File: source/decode_pkg.sv
package decode_pkg;

    ////////////////////////////////////////
    // field and bus widths
    ////////////////////////////////////////

    localparam int W_INSTR   = 32;
    localparam int W_REG_IDX = 5;
    localparam int W_OPCODE  = 7;
    localparam int W_FUNCT3  = 3;
    localparam int W_FUNCT7  = 7;
    localparam int W_IMM12   = 12;

    localparam int W_FMT     = 3;
    localparam int W_PIPE    = 4;
    localparam int W_UOP     = 6;
    localparam int W_UOP_GRP = 3;
    localparam int W_UOP_VAR = 3;

    ////////////////////////////////////////
    // base opcodes, RV32I + M
    ////////////////////////////////////////

    localparam logic [W_OPCODE-1:0] OPC_OP       = 7'b0110011;
    localparam logic [W_OPCODE-1:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [W_OPCODE-1:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [W_OPCODE-1:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [W_OPCODE-1:0] OPC_JAL      = 7'b1101111;
    localparam logic [W_OPCODE-1:0] OPC_JALR     = 7'b1100111;
    localparam logic [W_OPCODE-1:0] OPC_LOAD     = 7'b0000011;
    localparam logic [W_OPCODE-1:0] OPC_LUI      = 7'b0110111;
    localparam logic [W_OPCODE-1:0] OPC_STORE    = 7'b0100011;
    localparam logic [W_OPCODE-1:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [W_OPCODE-1:0] OPC_SYSTEM   = 7'b1110011;

    // funct7 selectors for the register-register opcode
    localparam logic [W_FUNCT7-1:0] F7_BASE   = 7'b0000000;
    localparam logic [W_FUNCT7-1:0] F7_ALT    = 7'b0100000;
    localparam logic [W_FUNCT7-1:0] F7_MULDIV = 7'b0000001;

    ////////////////////////////////////////
    // encoding formats
    ////////////////////////////////////////

    localparam logic [W_FMT-1:0] FMT_R    = 3'd0;
    localparam logic [W_FMT-1:0] FMT_I    = 3'd1;
    localparam logic [W_FMT-1:0] FMT_S    = 3'd2;
    localparam logic [W_FMT-1:0] FMT_B    = 3'd3;
    localparam logic [W_FMT-1:0] FMT_U    = 3'd4;
    localparam logic [W_FMT-1:0] FMT_J    = 3'd5;
    localparam logic [W_FMT-1:0] FMT_NONE = 3'd7;

    ////////////////////////////////////////
    // execution pipes
    ////////////////////////////////////////

    localparam logic [W_PIPE-1:0] PIPE_NONE = 4'd0;
    localparam logic [W_PIPE-1:0] PIPE_EXEC = 4'd1;
    localparam logic [W_PIPE-1:0] PIPE_DIV  = 4'd2;
    // control-status register pipe
    localparam logic [W_PIPE-1:0] PIPE_CSR  = 4'd3;
    localparam logic [W_PIPE-1:0] PIPE_LS   = 4'd4;

    // micro-op groups, upper half of the micro-op
    localparam logic [W_UOP_GRP-1:0] UOP_GRP_0 = 3'd0;
    localparam logic [W_UOP_GRP-1:0] UOP_GRP_1 = 3'd1;
    localparam logic [W_UOP_GRP-1:0] UOP_GRP_2 = 3'd2;
    localparam logic [W_UOP_GRP-1:0] UOP_GRP_3 = 3'd3;
    localparam logic [W_UOP_GRP-1:0] UOP_GRP_4 = 3'd4;

    ////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [W_FUNCT7-1:0]  funct7;
        logic [W_REG_IDX-1:0] rs2;
        logic [W_REG_IDX-1:0] rs1;
        logic [W_FUNCT3-1:0]  funct3;
        logic [W_REG_IDX-1:0] rd;
        logic [W_OPCODE-1:0]  opcode;
    } r_form_t;

    // imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [W_IMM12-1:0]   imm12;
        logic [W_REG_IDX-1:0] rs1;
        logic [W_FUNCT3-1:0]  funct3;
        logic [W_REG_IDX-1:0] rd;
        logic [W_OPCODE-1:0]  opcode;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_word_u;

endpackage

// File: source/format_stage.sv
module format_stage (
    input  logic                          con_cmd,
    input  logic                          i_rst,
    input  logic                          i_pause,
    input  logic                          i_valid,
    input  decode_pkg::instr_word_u       i_instr,
    output logic                          o_valid,
    output decode_pkg::instr_word_u       o_instr,
    output logic [decode_pkg::W_FMT-1:0]  o_fmt,
    output logic [decode_pkg::W_PIPE-1:0] o_pipe
);

    import decode_pkg::*;

    logic [W_OPCODE-1:0] opcode;
    logic [W_FUNCT3-1:0] funct3;
    logic [W_FUNCT7-1:0] funct7;
    logic [W_FMT-1:0]    fmt_next;
    logic [W_PIPE-1:0]   pipe_next;
    logic                is_div;

    assign opcode = i_instr.r_form.opcode;
    assign funct3 = i_instr.r_form.funct3;
    assign funct7 = i_instr.r_form.funct7;

    // div/rem/divu/remu sit at funct3 4..7 of the M block
    assign is_div = (opcode == OPC_OP) && (funct7 == F7_MULDIV) && funct3[2];

    ////////////////////////////////////////
    // format decode
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_OP: begin
                fmt_next = FMT_R;
            end
            OPC_OP_IMM, OPC_JALR, OPC_LOAD, OPC_MISC_MEM, OPC_SYSTEM: begin
                fmt_next = FMT_I;
            end
            OPC_STORE: begin
                fmt_next = FMT_S;
            end
            OPC_BRANCH: begin
                fmt_next = FMT_B;
            end
            OPC_LUI, OPC_AUIPC: begin
                fmt_next = FMT_U;
            end
            OPC_JAL: begin
                fmt_next = FMT_J;
            end
            default: begin
                fmt_next = FMT_NONE;
            end
        endcase
    end

    ////////////////////////////////////////
    // pipe select
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_BRANCH, OPC_AUIPC, OPC_JAL, OPC_JALR: begin
                // multiplies stay in execute, divides go to the divider
                pipe_next = is_div ? PIPE_DIV : PIPE_EXEC;
            end
            OPC_LOAD, OPC_LUI, OPC_STORE, OPC_MISC_MEM: begin
                pipe_next = PIPE_LS;
            end
            OPC_SYSTEM: begin
                pipe_next = PIPE_CSR;
            end
            default: begin
                pipe_next = PIPE_NONE;
            end
        endcase
    end

    // stage register, frozen while paused
    always_ff @(posedge con_cmd) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_instr <= '0;
            o_fmt   <= '0;
            o_pipe  <= '0;
        end else if (!i_pause) begin
            o_valid <= i_valid;
            // payload only moves with a strobe
            if (i_valid) begin
                o_instr <= i_instr;
                o_fmt   <= fmt_next;
                o_pipe  <= pipe_next;
            end
        end
    end

endmodule

// File: source/uop_stage.sv
module uop_stage (
    input  logic                             con_cmd,
    input  logic                             i_rst,
    input  logic                             i_pause,
    input  logic                             i_valid,
    input  decode_pkg::instr_word_u          i_instr,
    input  logic [decode_pkg::W_FMT-1:0]     i_fmt,
    input  logic [decode_pkg::W_PIPE-1:0]    i_pipe,
    output logic                             o_valid,
    output logic [decode_pkg::W_FMT-1:0]     o_fmt,
    output logic [decode_pkg::W_PIPE-1:0]    o_pipe,
    output logic [decode_pkg::W_UOP-1:0]     o_uop,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rd,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rs1,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rs2,
    output logic                             o_need_rs1,
    output logic                             o_need_rs2,
    output logic                             o_need_rd,
    output logic                             o_commit_store,
    output logic                             o_commit_load,
    output logic                             o_commit_wb
);

    import decode_pkg::*;

    logic [W_OPCODE-1:0]  opcode;
    logic [W_FUNCT3-1:0]  funct3;
    logic [W_FUNCT7-1:0]  funct7;
    logic                 sys_imm_bit;
    logic [W_UOP_GRP-1:0] uop_grp;
    logic [W_UOP_VAR-1:0] uop_var;
    logic                 need_rs1;
    logic                 need_rs2;
    logic                 need_rd;

    assign opcode = i_instr.r_form.opcode;
    assign funct3 = i_instr.r_form.funct3;
    assign funct7 = i_instr.r_form.funct7;
    // ecall vs ebreak lives in the low immediate bit
    assign sys_imm_bit = i_instr.i_form.imm12[0];

    ////////////////////////////////////////
    // micro-op decode
    ////////////////////////////////////////

    always_comb begin
        uop_grp = UOP_GRP_0;
        uop_var = 3'd0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_ALT) begin
                    // sub vs sra
                    uop_grp = UOP_GRP_1;
                    uop_var = (funct3 == 3'd0) ? 3'd4 : 3'd5;
                end else if (funct7 == F7_MULDIV) begin
                    uop_grp = UOP_GRP_1;
                    uop_var = funct3;
                end else begin
                    uop_grp = UOP_GRP_0;
                    uop_var = funct3;
                end
            end
            OPC_OP_IMM: begin
                uop_grp = UOP_GRP_2;
                uop_var = funct3;
            end
            OPC_BRANCH: begin
                uop_grp = UOP_GRP_3;
                uop_var = funct3;
            end
            OPC_AUIPC: begin
                uop_grp = UOP_GRP_4;
                uop_var = 3'd0;
            end
            OPC_JAL: begin
                uop_grp = UOP_GRP_4;
                uop_var = 3'd1;
            end
            OPC_JALR: begin
                uop_grp = UOP_GRP_4;
                uop_var = 3'd2;
            end
            OPC_LOAD: begin
                uop_grp = UOP_GRP_0;
                uop_var = funct3;
            end
            OPC_LUI: begin
                // shares group 0 with loads, variant 3 is free there
                uop_grp = UOP_GRP_0;
                uop_var = 3'd3;
            end
            OPC_STORE: begin
                uop_grp = UOP_GRP_1;
                uop_var = funct3;
            end
            OPC_MISC_MEM: begin
                uop_grp = UOP_GRP_2;
                uop_var = funct3;
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'd0) begin
                    uop_grp = UOP_GRP_0;
                    uop_var = {2'b00, sys_imm_bit};
                end else begin
                    uop_grp = UOP_GRP_1;
                    uop_var = funct3;
                end
            end
            default: begin
                uop_grp = UOP_GRP_0;
                uop_var = 3'd0;
            end
        endcase
    end

    // operand use follows the encoding format
    assign need_rs1 = (i_fmt == FMT_R) || (i_fmt == FMT_I) ||
                      (i_fmt == FMT_S) || (i_fmt == FMT_B);
    assign need_rs2 = (i_fmt == FMT_R) || (i_fmt == FMT_S) || (i_fmt == FMT_B);
    assign need_rd  = (i_fmt == FMT_R) || (i_fmt == FMT_I) ||
                      (i_fmt == FMT_U) || (i_fmt == FMT_J);

    ////////////////////////////////////////
    // result register
    ////////////////////////////////////////

    always_ff @(posedge con_cmd) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_fmt          <= '0;
            o_pipe         <= '0;
            o_uop          <= '0;
            o_rd           <= '0;
            o_rs1          <= '0;
            o_rs2          <= '0;
            o_need_rs1     <= 1'b0;
            o_need_rs2     <= 1'b0;
            o_need_rd      <= 1'b0;
            o_commit_store <= 1'b0;
            o_commit_load  <= 1'b0;
            o_commit_wb    <= 1'b0;
        end else if (!i_pause) begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_fmt          <= i_fmt;
                o_pipe         <= i_pipe;
                o_uop          <= {uop_grp, uop_var};
                o_rd           <= i_instr.r_form.rd;
                o_rs1          <= i_instr.r_form.rs1;
                o_rs2          <= i_instr.r_form.rs2;
                o_need_rs1     <= need_rs1;
                o_need_rs2     <= need_rs2;
                o_need_rd      <= need_rd;
                // commit director flags
                o_commit_store <= (opcode == OPC_STORE);
                o_commit_load  <= (opcode == OPC_LOAD);
                o_commit_wb    <= need_rd;
            end
        end
    end

endmodule

// File: source/decode_top.sv
module decode_top (
    input  logic                             con_cmd,
    input  logic                             i_rst,
    input  logic                             i_valid,
    input  decode_pkg::instr_word_u          i_instr,
    input  logic                             i_pause,
    output logic                             o_valid,
    output logic [decode_pkg::W_FMT-1:0]     o_fmt,
    output logic [decode_pkg::W_PIPE-1:0]    o_pipe,
    output logic [decode_pkg::W_UOP-1:0]     o_uop,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rd,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rs1,
    output logic [decode_pkg::W_REG_IDX-1:0] o_rs2,
    output logic                             o_need_rs1,
    output logic                             o_need_rs2,
    output logic                             o_need_rd,
    output logic                             o_commit_store,
    output logic                             o_commit_load,
    output logic                             o_commit_wb
);

    import decode_pkg::*;

    // stage 1 to stage 2
    logic               s1_valid;
    instr_word_u        s1_instr;
    logic [W_FMT-1:0]   s1_fmt;
    logic [W_PIPE-1:0]  s1_pipe;

    format_stage u_format_stage (
        .con_cmd (con_cmd),
        .i_rst   (i_rst),
        .i_pause (i_pause),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .o_valid (s1_valid),
        .o_instr (s1_instr),
        .o_fmt   (s1_fmt),
        .o_pipe  (s1_pipe)
    );

    uop_stage u_uop_stage (
        .con_cmd        (con_cmd),
        .i_rst          (i_rst),
        .i_pause        (i_pause),
        .i_valid        (s1_valid),
        .i_instr        (s1_instr),
        .i_fmt          (s1_fmt),
        .i_pipe         (s1_pipe),
        .o_valid        (o_valid),
        .o_fmt          (o_fmt),
        .o_pipe         (o_pipe),
        .o_uop          (o_uop),
        .o_rd           (o_rd),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_need_rs1     (o_need_rs1),
        .o_need_rs2     (o_need_rs2),
        .o_need_rd      (o_need_rd),
        .o_commit_store (o_commit_store),
        .o_commit_load  (o_commit_load),
        .o_commit_wb    (o_commit_wb)
    );

endmodule

// File: verification/decode_asserts.sv
module decode_asserts (
    input logic                             con_cmd,
    input logic                             i_rst,
    input logic                             i_pause,
    input logic                             o_valid,
    input logic [decode_pkg::W_FMT-1:0]     o_fmt,
    input logic [decode_pkg::W_PIPE-1:0]    o_pipe,
    input logic [decode_pkg::W_UOP-1:0]     o_uop,
    input logic [decode_pkg::W_REG_IDX-1:0] o_rd,
    input logic [decode_pkg::W_REG_IDX-1:0] o_rs1,
    input logic [decode_pkg::W_REG_IDX-1:0] o_rs2,
    input logic                             o_need_rs1,
    input logic                             o_need_rs2,
    input logic                             o_need_rd,
    input logic                             o_commit_store,
    input logic                             o_commit_load,
    input logic                             o_commit_wb
);

    import decode_pkg::*;

    // failed assertions so far
    int fail_count = 0;

    assert property (@(posedge con_cmd) i_rst |=> !o_valid)
        else begin
            $error("o_valid high in the cycle after reset");
            fail_count++;
        end

    // only the five defined pipes may leave the decoder
    assert property (@(posedge con_cmd) disable iff (i_rst) o_valid |-> (o_pipe <= PIPE_LS))
        else begin
            $error("o_pipe out of range while o_valid is high");
            fail_count++;
        end

    // a paused edge freezes the whole result register
    assert property (@(posedge con_cmd) disable iff (i_rst)
        i_pause |=> $stable({o_valid, o_fmt, o_pipe, o_uop, o_rd, o_rs1, o_rs2,
                             o_need_rs1, o_need_rs2, o_need_rd,
                             o_commit_store, o_commit_load, o_commit_wb}))
        else begin
            $error("outputs changed across a paused cycle");
            fail_count++;
        end

endmodule

bind decode_top decode_asserts u_decode_asserts (.*);

// File: verification/decode_tb.sv
module decode_tb;

    import decode_pkg::*;

    localparam int MAX_TESTS = 32;

    logic                 con_cmd;
    logic                 i_rst;
    logic                 i_valid;
    logic                 i_pause;
    instr_word_u          i_instr;
    logic                 o_valid;
    logic [W_FMT-1:0]     o_fmt;
    logic [W_PIPE-1:0]    o_pipe;
    logic [W_UOP-1:0]     o_uop;
    logic [W_REG_IDX-1:0] o_rd;
    logic [W_REG_IDX-1:0] o_rs1;
    logic [W_REG_IDX-1:0] o_rs2;
    logic                 o_need_rs1;
    logic                 o_need_rs2;
    logic                 o_need_rd;
    logic                 o_commit_store;
    logic                 o_commit_load;
    logic                 o_commit_wb;

    // stimulus table with flags as {need rs1, rs2, rd, commit store, load, wb}
    string             t_name  [MAX_TESTS];
    instr_word_u       t_instr [MAX_TESTS];
    logic [W_FMT-1:0]  t_fmt   [MAX_TESTS];
    logic [W_PIPE-1:0] t_pipe  [MAX_TESTS];
    logic [W_UOP-1:0]  t_uop   [MAX_TESTS];
    logic [5:0]        t_flags [MAX_TESTS];

    int q_idx[$];
    int q_cyc[$];
    int q_pause[$];
    int n_entries = 0;
    int cur_idx = 0;
    int cyc = 0;
    int pause_cyc = 0;
    int test_errs = 0;
    int n_done = 0;
    int n_pass = 0;
    int n_fail = 0;
    int n_extra = 0;

    decode_top UUT (.*);

    initial begin
        con_cmd = 1'b0;
        forever #4 con_cmd = ~con_cmd;
    end

    ////////////////////////////////////////
    // table helpers
    ////////////////////////////////////////

    function automatic instr_word_u encode(input logic [W_FUNCT7-1:0] f7,
            input logic [W_REG_IDX-1:0] rs2, input logic [W_REG_IDX-1:0] rs1,
            input logic [W_FUNCT3-1:0] f3, input logic [W_REG_IDX-1:0] rd,
            input logic [W_OPCODE-1:0] opc);
        instr_word_u w;
        w.r_form.funct7 = f7;
        w.r_form.rs2    = rs2;
        w.r_form.rs1    = rs1;
        w.r_form.funct3 = f3;
        w.r_form.rd     = rd;
        w.r_form.opcode = opc;
        return w;
    endfunction

    task automatic add_entry(input string name, input instr_word_u word,
            input logic [W_FMT-1:0] fmt, input logic [W_PIPE-1:0] pipe,
            input logic [W_UOP-1:0] uop, input logic [5:0] flags);
        t_name[n_entries]  = name;
        t_instr[n_entries] = word;
        t_fmt[n_entries]   = fmt;
        t_pipe[n_entries]  = pipe;
        t_uop[n_entries]   = uop;
        t_flags[n_entries] = flags;
        n_entries++;
    endtask

    // uop octal digits are group then variant
    task automatic build_table();
        add_entry("add", encode(F7_BASE, 2, 1, 0, 3, OPC_OP), FMT_R, PIPE_EXEC, 6'o00, 6'o71);
        add_entry("sub", encode(F7_ALT, 5, 4, 0, 6, OPC_OP), FMT_R, PIPE_EXEC, 6'o14, 6'o71);
        add_entry("sra", encode(F7_ALT, 7, 8, 5, 9, OPC_OP), FMT_R, PIPE_EXEC, 6'o15, 6'o71);
        add_entry("slt", encode(F7_BASE, 3, 2, 2, 1, OPC_OP), FMT_R, PIPE_EXEC, 6'o02, 6'o71);
        add_entry("mulh", encode(F7_MULDIV, 9, 8, 1, 7, OPC_OP), FMT_R, PIPE_EXEC, 6'o11, 6'o71);
        add_entry("mulhu", encode(F7_MULDIV, 1, 2, 3, 4, OPC_OP), FMT_R, PIPE_EXEC, 6'o13, 6'o71);
        add_entry("div", encode(F7_MULDIV, 6, 5, 4, 10, OPC_OP), FMT_R, PIPE_DIV, 6'o14, 6'o71);
        add_entry("remu", encode(F7_MULDIV, 12, 11, 7, 13, OPC_OP), FMT_R, PIPE_DIV, 6'o17, 6'o71);
        add_entry("addi", encode(F7_BASE, 10, 11, 0, 12, OPC_OP_IMM), FMT_I, PIPE_EXEC, 6'o20, 6'o51);
        add_entry("srai", encode(F7_ALT, 3, 13, 5, 14, OPC_OP_IMM), FMT_I, PIPE_EXEC, 6'o25, 6'o51);
        add_entry("bne", encode(F7_BASE, 15, 16, 1, 0, OPC_BRANCH), FMT_B, PIPE_EXEC, 6'o31, 6'o60);
        add_entry("bgeu", encode(F7_BASE, 5, 6, 7, 2, OPC_BRANCH), FMT_B, PIPE_EXEC, 6'o37, 6'o60);
        add_entry("auipc", encode(7'h12, 17, 18, 3, 19, OPC_AUIPC), FMT_U, PIPE_EXEC, 6'o40, 6'o11);
        add_entry("jal", encode(7'h01, 20, 21, 6, 1, OPC_JAL), FMT_J, PIPE_EXEC, 6'o41, 6'o11);
        add_entry("jalr", encode(F7_BASE, 4, 22, 0, 1, OPC_JALR), FMT_I, PIPE_EXEC, 6'o42, 6'o51);
        add_entry("lw", encode(F7_BASE, 8, 23, 2, 24, OPC_LOAD), FMT_I, PIPE_LS, 6'o02, 6'o53);
        add_entry("lui", encode(7'h55, 25, 26, 4, 27, OPC_LUI), FMT_U, PIPE_LS, 6'o03, 6'o11);
        add_entry("sw", encode(F7_BASE, 28, 29, 2, 4, OPC_STORE), FMT_S, PIPE_LS, 6'o12, 6'o64);
        add_entry("fence", encode(7'h08, 15, 0, 0, 0, OPC_MISC_MEM), FMT_I, PIPE_LS, 6'o20, 6'o51);
        add_entry("ecall", encode(F7_BASE, 0, 0, 0, 0, OPC_SYSTEM), FMT_I, PIPE_CSR, 6'o00, 6'o51);
        add_entry("ebreak", encode(F7_BASE, 1, 0, 0, 0, OPC_SYSTEM), FMT_I, PIPE_CSR, 6'o01, 6'o51);
        add_entry("csrrs", encode(7'h18, 2, 30, 2, 31, OPC_SYSTEM), FMT_I, PIPE_CSR, 6'o12, 6'o51);
        add_entry("bad_7f", encode(7'h7f, 31, 31, 7, 31, 7'h7f), FMT_NONE, PIPE_NONE, 6'o00, 6'o00);
        add_entry("bad_00", encode(F7_BASE, 0, 0, 0, 0, 7'h00), FMT_NONE, PIPE_NONE, 6'o00, 6'o00);
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_fmt(input string name, input logic [W_FMT-1:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s fmt: expected %0d, actual %0d", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_pipe(input string name, input logic [W_PIPE-1:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s pipe: expected %0d, actual %0d", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_uop(input string name, input logic [W_UOP-1:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s uop: expected %o, actual %o", name, exp, act);
            test_errs++;
        end
    endtask

    // indices come straight from the word fields
    task automatic check_regs(input string name, input instr_word_u word,
            input logic [W_REG_IDX-1:0] rd, rs1, rs2);
        if ({rd, rs1, rs2} !== {word.r_form.rd, word.r_form.rs1, word.r_form.rs2}) begin
            $display("ERR %s rd/rs1/rs2: expected %0d/%0d/%0d, actual %0d/%0d/%0d", name,
                     word.r_form.rd, word.r_form.rs1, word.r_form.rs2, rd, rs1, rs2);
            test_errs++;
        end
    endtask

    task automatic check_flags(input string name, input logic [5:0] exp, act);
        if (act !== exp) begin
            $display("ERR %s need/commit flags: expected %b, actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    always @(posedge con_cmd) begin : scoreboard
        int idx;
        int lat;
        if (!i_rst) begin
            if (i_valid && !i_pause) begin
                q_idx.push_back(cur_idx);
                q_cyc.push_back(cyc);
                q_pause.push_back(pause_cyc);
            end
            // a result leaves the output on an unpaused edge
            if (o_valid && !i_pause) begin
                if (q_idx.size() == 0) begin
                    $display("o_valid was high with no instruction outstanding");
                    n_extra++;
                end else begin
                    idx = q_idx.pop_front();
                    lat = cyc - q_cyc.pop_front() - (pause_cyc - q_pause.pop_front());
                    test_errs = 0;
                    check_fmt(t_name[idx], t_fmt[idx], o_fmt);
                    check_pipe(t_name[idx], t_pipe[idx], o_pipe);
                    check_uop(t_name[idx], t_uop[idx], o_uop);
                    check_regs(t_name[idx], t_instr[idx], o_rd, o_rs1, o_rs2);
                    check_flags(t_name[idx], t_flags[idx], {o_need_rs1, o_need_rs2, o_need_rd,
                                o_commit_store, o_commit_load, o_commit_wb});
                    // unpaused latency is two cycles
                    if (lat != 2) begin
                        $display("%s took %0d unpaused cycles instead of 2", t_name[idx], lat);
                        test_errs++;
                    end
                    if (test_errs == 0) begin
                        n_pass++;
                        $display("ok   %s", t_name[idx]);
                    end else begin
                        n_fail++;
                        $display("FAIL %s with %0d mismatches", t_name[idx], test_errs);
                    end
                    n_done++;
                end
            end
            if (i_pause) begin
                pause_cyc++;
            end
            cyc++;
        end
    end

    initial begin : main
        int gap;
        int burst;
        int limit;
        void'($urandom(32'h3a66_7253));
        i_rst   = 1'b1;
        i_valid = 1'b0;
        i_pause = 1'b0;
        i_instr = '0;
        build_table();
        limit = n_entries * (2 + 3 + 3 + 2) * 8 + 8 * 8;
        fork
            begin
                #(limit);
                $display("watchdog ran out after %0d time units, %0d of %0d tests done",
                         limit, n_done, n_entries);
                $display("Test failures found");
                $finish;
            end
        join_none
        repeat (8) @(posedge con_cmd);
        i_rst <= 1'b0;
        for (int k = 0; k < n_entries; k++) begin
            gap   = $urandom_range(3, 0);
            burst = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge con_cmd);
                i_valid <= 1'b0;
            end
            // strobe held through the pause burst until accepted
            @(posedge con_cmd);
            i_valid <= 1'b1;
            i_instr <= t_instr[k];
            cur_idx <= k;
            i_pause <= (burst > 0);
            repeat (burst) @(posedge con_cmd);
            i_pause <= 1'b0;
        end
        @(posedge con_cmd);
        i_valid <= 1'b0;
        wait (n_done == n_entries);
        repeat (4) @(posedge con_cmd);
        $display("tests %0d, passed %0d, failed %0d, unexpected outputs %0d, assertion errors %0d",
                 n_entries, n_pass, n_fail, n_extra, UUT.u_decode_asserts.fail_count);
        if (n_fail == 0 && n_extra == 0 && UUT.u_decode_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: decode_top.f
source/decode_pkg.sv
source/format_stage.sv
source/uop_stage.sv
source/decode_top.sv
verification/decode_asserts.sv
verification/decode_tb.sv

// File: Bender.yml
package:
  name: decode_top

sources:
  - source/decode_pkg.sv
  - source/format_stage.sv
  - source/uop_stage.sv
  - source/decode_top.sv
  - target: simulation
    files:
      - verification/decode_asserts.sv
      - verification/decode_tb.sv
